/* design/epd_pkg.sv */
// EPD controller package with shared widths and the Wishbone register map
package epd_pkg;

    // Pixel and state word geometry
    localparam int PIX_PER_CLK = 4;
    localparam int GRAY_BITS   = 4;
    localparam int FCNT_BITS   = 6;
    // Source gray 3:0, target gray 7:4, frames left 13:8, spare 15:14
    localparam int STATE_BITS  = 16;

    // Waveform table, read side is {sequence, target, source}
    localparam int LUT_ADDR_BITS  = 14;
    // Write side addresses whole bytes of four entries
    localparam int LUT_WADDR_BITS = 12;

    // Scan counters
    localparam int CNT_BITS = 11;

    // Register word addresses
    localparam logic [2:0] REG_CTRL      = 3'd0;
    localparam logic [2:0] REG_HTIM      = 3'd1;
    localparam logic [2:0] REG_HACT      = 3'd2;
    localparam logic [2:0] REG_VTIM      = 3'd3;
    localparam logic [2:0] REG_VACT      = 3'd4;
    localparam logic [2:0] REG_LUTFRAMES = 3'd5;
    localparam logic [2:0] REG_LUTWR     = 3'd6;
    localparam logic [2:0] REG_STATUS    = 3'd7;

endpackage

/* design/csr_wb.sv */
// Wishbone classic register slave holding timing, enable, frame count and table writes
`timescale 1ns/1ps

module csr_wb #(
    parameter logic [7:0]  DEF_HFP   = 8'd2,
    parameter logic [7:0]  DEF_HSYNC = 8'd1,
    parameter logic [7:0]  DEF_HBP   = 8'd2,
    parameter logic [11:0] DEF_HACT  = 12'd40,
    parameter logic [7:0]  DEF_VFP   = 8'd3,
    parameter logic [7:0]  DEF_VSYNC = 8'd1,
    parameter logic [7:0]  DEF_VBP   = 8'd2,
    parameter logic [11:0] DEF_VACT  = 12'd120,
    parameter logic [epd_pkg::FCNT_BITS-1:0] DEF_LUTFRAMES = 6'd20
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [2:0]                         wb_adr,
    input  logic [31:0]                        wb_dat_w,
    output logic [31:0]                        wb_dat_r,
    output logic                               wb_ack,
    input  logic                               sys_ready,
    input  logic                               scanning,
    output logic                               enable,
    output logic [7:0]                         hfp,
    output logic [7:0]                         hsync,
    output logic [7:0]                         hbp,
    output logic [11:0]                        hact,
    output logic [7:0]                         vfp,
    output logic [7:0]                         vsync,
    output logic [7:0]                         vbp,
    output logic [11:0]                        vact,
    output logic [epd_pkg::FCNT_BITS-1:0]      lut_frames,
    output logic                               lut_we,
    output logic [epd_pkg::LUT_WADDR_BITS-1:0] lut_waddr,
    output logic [7:0]                         lut_wdata
);
    import epd_pkg::*;

    logic wr_en;

    // One ack per access, the cycle after the request appears
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    // Writes land on the acked cycle
    assign wr_en = wb_ack && wb_cyc && wb_stb && wb_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable     <= 1'b0;
            {hbp, hsync, hfp} <= {DEF_HBP, DEF_HSYNC, DEF_HFP};
            hact       <= DEF_HACT;
            {vbp, vsync, vfp} <= {DEF_VBP, DEF_VSYNC, DEF_VFP};
            vact       <= DEF_VACT;
            lut_frames <= DEF_LUTFRAMES;
        end else if (wr_en) begin
            case (wb_adr)
                REG_CTRL:      enable <= wb_dat_w[0];
                REG_HTIM:      {hbp, hsync, hfp} <= wb_dat_w[23:0];
                REG_HACT:      hact <= wb_dat_w[11:0];
                REG_VTIM:      {vbp, vsync, vfp} <= wb_dat_w[23:0];
                REG_VACT:      vact <= wb_dat_w[11:0];
                REG_LUTFRAMES: lut_frames <= wb_dat_w[FCNT_BITS-1:0];
                default:       ;
            endcase
        end
    end

    // Table byte write straight from the bus data
    assign lut_we    = wr_en && (wb_adr == REG_LUTWR);
    assign lut_waddr = wb_dat_w[8 +: LUT_WADDR_BITS];
    assign lut_wdata = wb_dat_w[7:0];

    always_comb begin
        case (wb_adr)
            REG_CTRL:      wb_dat_r = {31'd0, enable};
            REG_HTIM:      wb_dat_r = {8'd0, hbp, hsync, hfp};
            REG_HACT:      wb_dat_r = {20'd0, hact};
            REG_VTIM:      wb_dat_r = {8'd0, vbp, vsync, vfp};
            REG_VACT:      wb_dat_r = {20'd0, vact};
            REG_LUTFRAMES: wb_dat_r = {{(32 - FCNT_BITS){1'b0}}, lut_frames};
            REG_STATUS:    wb_dat_r = {30'd0, scanning, sys_ready};
            default:       wb_dat_r = 32'd0;
        endcase
    end

endmodule

/* design/scan_timing.sv */
// Scan FSM with line and frame counters, region decode and EPD driver control timing
`timescale 1ns/1ps

module scan_timing #(
    parameter int VS_DELAY       = 8,
    parameter int PIPELINE_DELAY = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        sys_ready,
    input  logic        vin_vsync,
    input  logic [7:0]  hfp,
    input  logic [7:0]  hsync,
    input  logic [7:0]  hbp,
    input  logic [11:0] hact,
    input  logic [7:0]  vfp,
    input  logic [7:0]  vsync,
    input  logic [7:0]  vbp,
    input  logic [11:0] vact,
    output logic        scanning,
    output logic        pix_accept,
    output logic        epd_gdoe,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdclk,
    output logic        epd_sdle,
    output logic        epd_sdoe,
    output logic        epd_sdce0
);
    import epd_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_RUN  = 2'd2;

    logic [1:0]          state;
    logic [CNT_BITS-1:0] h_cnt;
    logic [CNT_BITS-1:0] v_cnt;
    logic [CNT_BITS-1:0] h_sync_start, h_bp_start, h_act_start, htotal;
    logic [CNT_BITS-1:0] v_sync_start, v_bp_start, v_act_start, vtotal;
    logic                running;
    logic                in_hfp, in_hsync, in_hbp, in_hact;
    logic                in_vsync, in_vbp, in_vact;
    logic                h_accept;
    logic                gdclk_q;

    // Region boundaries, fp starts at zero
    assign h_sync_start = CNT_BITS'(hfp);
    assign h_bp_start   = h_sync_start + CNT_BITS'(hsync);
    assign h_act_start  = h_bp_start + CNT_BITS'(hbp);
    assign htotal       = h_act_start + CNT_BITS'(hact);
    assign v_sync_start = CNT_BITS'(vfp);
    assign v_bp_start   = v_sync_start + CNT_BITS'(vsync);
    assign v_act_start  = v_bp_start + CNT_BITS'(vbp);
    assign vtotal       = v_act_start + CNT_BITS'(vact);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (enable && sys_ready && vin_vsync) begin
                        state <= ST_WAIT;
                    end
                end
                // h_cnt doubles as the vsync delay counter
                ST_WAIT: begin
                    if (h_cnt == CNT_BITS'(VS_DELAY)) begin
                        state <= ST_RUN;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                ST_RUN: begin
                    if (h_cnt == htotal - 1'b1) begin
                        h_cnt <= '0;
                        if (v_cnt == vtotal - 1'b1) begin
                            state <= ST_IDLE;
                            v_cnt <= '0;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign scanning = (state != ST_IDLE);
    assign running  = (state == ST_RUN);

    assign in_hfp   = running && (h_cnt < h_sync_start);
    assign in_hsync = running && (h_cnt >= h_sync_start) && (h_cnt < h_bp_start);
    assign in_hbp   = running && (h_cnt >= h_bp_start) && (h_cnt < h_act_start);
    assign in_hact  = running && (h_cnt >= h_act_start);
    assign in_vsync = running && (v_cnt >= v_sync_start) && (v_cnt < v_bp_start);
    assign in_vbp   = running && (v_cnt >= v_bp_start) && (v_cnt < v_act_start);
    assign in_vact  = running && (v_cnt >= v_act_start);

    // Accept window leads horizontal active by the pipeline depth
    assign h_accept = (h_cnt >= h_act_start - CNT_BITS'(PIPELINE_DELAY))
                   && (h_cnt < htotal - CNT_BITS'(PIPELINE_DELAY));
    assign pix_accept = in_vact && h_accept;

    // Gate clock lags the line regions by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            gdclk_q <= 1'b0;
        end else begin
            gdclk_q <= in_hsync || in_hbp || in_hact;
        end
    end

    assign epd_gdclk = gdclk_q;
    assign epd_gdoe  = in_vsync || in_vbp || in_vact;
    assign epd_sdoe  = epd_gdoe;
    assign epd_gdsp  = !in_vsync;
    assign epd_sdle  = in_hsync;
    assign epd_sdce0 = !(in_vact && in_hact);
    assign epd_sdclk = (in_hfp || in_hsync || in_hact) ? ~clk : 1'b0;

endmodule

/* design/wvfm_lut.sv */
// Waveform table with one byte write port and four registered 2-bit read ports
`timescale 1ns/1ps

module wvfm_lut (
    input  logic                               clk,
    input  logic                               we,
    input  logic [epd_pkg::LUT_WADDR_BITS-1:0] waddr,
    input  logic [7:0]                         wdata,
    input  logic [epd_pkg::LUT_ADDR_BITS-1:0]  raddr0,
    input  logic [epd_pkg::LUT_ADDR_BITS-1:0]  raddr1,
    input  logic [epd_pkg::LUT_ADDR_BITS-1:0]  raddr2,
    input  logic [epd_pkg::LUT_ADDR_BITS-1:0]  raddr3,
    output logic [1:0]                         rdata0,
    output logic [1:0]                         rdata1,
    output logic [1:0]                         rdata2,
    output logic [1:0]                         rdata3
);
    import epd_pkg::*;

    logic [7:0] mem [2**LUT_WADDR_BITS];

    // Upper address bits pick the byte, low two bits pick the entry
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata0 <= mem[raddr0[LUT_ADDR_BITS-1:2]][{raddr0[1:0], 1'b0} +: 2];
        rdata1 <= mem[raddr1[LUT_ADDR_BITS-1:2]][{raddr1[1:0], 1'b0} +: 2];
        rdata2 <= mem[raddr2[LUT_ADDR_BITS-1:2]][{raddr2[1:0], 1'b0} +: 2];
        rdata3 <= mem[raddr3[LUT_ADDR_BITS-1:2]][{raddr3[1:0], 1'b0} +: 2];
    end

endmodule

/* design/pixel_pipeline.sv */
// Pixel pipeline forming waveform addresses, updating pixel states and driving source data
`timescale 1ns/1ps

module pixel_pipeline (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pix_accept,
    input  logic [31:0]                       vin_pixel,
    input  logic [63:0]                       bi_pixel,
    input  logic [epd_pkg::FCNT_BITS-1:0]     lut_frames,
    output logic [epd_pkg::LUT_ADDR_BITS-1:0] raddr0,
    output logic [epd_pkg::LUT_ADDR_BITS-1:0] raddr1,
    output logic [epd_pkg::LUT_ADDR_BITS-1:0] raddr2,
    output logic [epd_pkg::LUT_ADDR_BITS-1:0] raddr3,
    input  logic [1:0]                        rdata0,
    input  logic [1:0]                        rdata1,
    input  logic [1:0]                        rdata2,
    input  logic [1:0]                        rdata3,
    output logic [7:0]                        epd_sd,
    output logic [63:0]                       bo_pixel,
    output logic                              bo_valid
);
    import epd_pkg::*;

    localparam int LEFT_LSB = 2 * GRAY_BITS;
    localparam int KEEP_LSB = LEFT_LSB + FCNT_BITS;

    logic [LUT_ADDR_BITS-1:0] addr [PIX_PER_CLK];
    logic [1:0]               lut_code [PIX_PER_CLK];
    logic                     s1_valid;
    logic [15:0]              s1_y4;
    logic [63:0]              s1_state;
    logic [7:0]               sd_next;
    logic [63:0]              bo_next;

    assign {raddr3, raddr2, raddr1, raddr0} = {addr[3], addr[2], addr[1], addr[0]};
    assign {lut_code[3], lut_code[2]} = {rdata3, rdata2};
    assign {lut_code[1], lut_code[0]} = {rdata1, rdata0};

    // Stage 1, table addresses come straight from the incoming state words
    always_ff @(posedge clk) begin
        if (pix_accept) begin
            s1_state <= bi_pixel;
            for (int i = 0; i < PIX_PER_CLK; i++) begin
                s1_y4[i*GRAY_BITS +: GRAY_BITS] <= vin_pixel[i*8 + 8 - GRAY_BITS +: GRAY_BITS];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pix_accept;
        end
    end

    for (genvar i = 0; i < PIX_PER_CLK; i++) begin : g_pix
        logic [STATE_BITS-1:0] st_in;
        logic [STATE_BITS-1:0] st;
        logic [GRAY_BITS-1:0]  src, tgt, y4;
        logic [FCNT_BITS-1:0]  left, left_dec;

        // Sequence counts up as frames left runs down
        assign st_in   = bi_pixel[i*STATE_BITS +: STATE_BITS];
        assign addr[i] = {lut_frames - st_in[LEFT_LSB +: FCNT_BITS],
                          st_in[GRAY_BITS +: GRAY_BITS], st_in[GRAY_BITS-1:0]};

        // Stage 2 state update
        assign st       = s1_state[i*STATE_BITS +: STATE_BITS];
        assign src      = st[GRAY_BITS-1:0];
        assign tgt      = st[GRAY_BITS +: GRAY_BITS];
        assign left     = st[LEFT_LSB +: FCNT_BITS];
        assign left_dec = left - 1'b1;
        assign y4       = s1_y4[i*GRAY_BITS +: GRAY_BITS];

        always_comb begin
            if (left == '0) begin
                sd_next[2*i +: 2] = 2'b00;
                if (y4 != src) begin
                    // New target, start a fresh waveform
                    bo_next[i*STATE_BITS +: STATE_BITS] =
                        {st[STATE_BITS-1:KEEP_LSB], lut_frames, y4, src};
                end else begin
                    bo_next[i*STATE_BITS +: STATE_BITS] = st;
                end
            end else begin
                sd_next[2*i +: 2] = lut_code[i];
                bo_next[i*STATE_BITS +: STATE_BITS] =
                    {st[STATE_BITS-1:KEEP_LSB], left_dec, tgt, (left_dec == '0) ? tgt : src};
            end
        end
    end

    // Output registers, source data idles at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            bo_valid <= 1'b0;
            epd_sd   <= 8'd0;
        end else begin
            bo_valid <= s1_valid;
            epd_sd   <= s1_valid ? sd_next : 8'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            bo_pixel <= bo_next;
        end
    end

endmodule

/* design/epd_controller.sv */
// EPD scan controller top level joining register slave, scan timing, waveform table and pipeline
`timescale 1ns/1ps

module epd_controller #(
    parameter logic [7:0]  H_FP   = 8'd2,
    parameter logic [7:0]  H_SYNC = 8'd1,
    parameter logic [7:0]  H_BP   = 8'd2,
    parameter logic [11:0] H_ACT  = 12'd40,
    parameter logic [7:0]  V_FP   = 8'd3,
    parameter logic [7:0]  V_SYNC = 8'd1,
    parameter logic [7:0]  V_BP   = 8'd2,
    parameter logic [11:0] V_ACT  = 12'd120,
    parameter logic [epd_pkg::FCNT_BITS-1:0] LUT_FRAMES = 6'd20,
    parameter int          VS_DELAY       = 8,
    parameter int          PIPELINE_DELAY = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        vin_vsync,
    input  logic [31:0] vin_pixel,
    // Upstream holds valid high whenever ready is high
    input  logic        vin_valid,
    output logic        vin_ready,
    input  logic [63:0] bi_pixel,
    input  logic        bi_valid,
    output logic        bi_ready,
    output logic [63:0] bo_pixel,
    output logic        bo_valid,
    output logic        epd_gdoe,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdclk,
    output logic        epd_sdle,
    output logic        epd_sdoe,
    output logic [7:0]  epd_sd,
    output logic        epd_sdce0,
    input  logic        sys_ready,
    output logic        global_en
);
    import epd_pkg::*;

    logic                      enable, scanning, pix_accept;
    logic [7:0]                hfp, hsync, hbp, vfp, vsync, vbp;
    logic [11:0]               hact, vact;
    logic [FCNT_BITS-1:0]      lut_frames;
    logic                      lut_we;
    logic [LUT_WADDR_BITS-1:0] lut_waddr;
    logic [7:0]                lut_wdata;
    logic [LUT_ADDR_BITS-1:0]  raddr0, raddr1, raddr2, raddr3;
    logic [1:0]                rdata0, rdata1, rdata2, rdata3;

    csr_wb #(
        .DEF_HFP(H_FP), .DEF_HSYNC(H_SYNC), .DEF_HBP(H_BP), .DEF_HACT(H_ACT),
        .DEF_VFP(V_FP), .DEF_VSYNC(V_SYNC), .DEF_VBP(V_BP), .DEF_VACT(V_ACT),
        .DEF_LUTFRAMES(LUT_FRAMES)
    ) u_csr (.*);

    scan_timing #(
        .VS_DELAY(VS_DELAY),
        .PIPELINE_DELAY(PIPELINE_DELAY)
    ) u_scan (.*);

    wvfm_lut u_lut (
        .we(lut_we),
        .waddr(lut_waddr),
        .wdata(lut_wdata),
        .*
    );

    pixel_pipeline u_pipe (.*);

    // Both upstream streams advance together
    assign vin_ready = pix_accept;
    assign bi_ready  = pix_accept;
    assign global_en = enable;

endmodule

/* sim/epd_assert.sv */
// Concurrent checks on the Wishbone ack, the pixel handshake and the pipeline latency
`timescale 1ns/1ps

module epd_assert #(
    parameter int PIPELINE_DELAY = 2
) (
    input logic clk,
    input logic rst,
    input logic wb_stb,
    input logic wb_ack,
    input logic vin_ready,
    input logic bi_ready,
    input logic vin_valid,
    input logic bi_valid,
    input logic bo_valid
);

    // An ack only answers a live strobe
    ack_with_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
        else $error("wb_ack high while wb_stb is low");

    // Writeback follows each accepted beat after the pipeline depth
    bo_latency: assert property (@(posedge clk) disable iff (rst)
        bo_valid == $past(vin_ready, PIPELINE_DELAY))
        else $error("bo_valid does not trail vin_ready by the pipeline depth");

    // Upstream holds both streams valid during accept cycles
    valid_when_ready: assert property (@(posedge clk) disable iff (rst)
        (vin_ready || bi_ready) |-> (vin_valid && bi_valid))
        else $error("ready high without valid pixel and state data");

endmodule

bind epd_controller epd_assert #(.PIPELINE_DELAY(PIPELINE_DELAY)) u_assert (.*);

/* sim/tb_epd.sv */
// Testbench for the EPD scan controller with register, scan timing and pixel pipeline checks
`timescale 1ns/1ps

module tb_epd;
    import epd_pkg::*;

    localparam logic [31:0] SEED = 32'h670aabd8;
    localparam int HFP = 2;
    localparam int HSYNC = 1;
    localparam int HBP = 2;
    localparam int HACT = 6;
    localparam int VFP = 1;
    localparam int VSYNC = 2;
    localparam int VBP = 1;
    localparam int VACT = 4;
    localparam int HTOTAL = HFP + HSYNC + HBP + HACT;
    localparam int VTOTAL = VFP + VSYNC + VBP + VACT;
    localparam int VS_DELAY = 8;
    localparam int LUT_FR = 6;
    // Only sequences below LUT_FR are ever read, 64 bytes each
    localparam int LUT_BYTES = LUT_FR * 64;
    localparam int N_FRAMES = 3;
    // Register phase at four cycles per access
    localparam int REG_CYCLES = 4 * (8 * 3 + 8 * 6 + 16 + LUT_BYTES + 8) + 40;
    localparam int FRAME_CYCLES = N_FRAMES * (VS_DELAY + 1 + HTOTAL * VTOTAL + 20);
    localparam int CYCLE_LIMIT = 5 * (REG_CYCLES + FRAME_CYCLES);

    logic        clk = 1'b0;
    logic        rst;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic        vin_vsync, vin_valid, vin_ready;
    logic [31:0] vin_pixel;
    logic [63:0] bi_pixel, bo_pixel;
    logic        bi_valid, bi_ready, bo_valid;
    logic        epd_gdoe, epd_gdclk, epd_gdsp, epd_sdclk, epd_sdle, epd_sdoe, epd_sdce0;
    logic [7:0]  epd_sd;
    logic        sys_ready, global_en;

    logic [31:0] rng, pix_rng;
    logic [7:0]  tbl [4096];
    logic [71:0] exp_q [$];
    logic        rdy_d1, rdy_d2, sdle_d;
    // sdle pulses, gdsp low, sdce0 low, ready cycles, bo_valid cycles,
    // then gdoe high, sdoe high and gdclk high cycles
    int          cnt [8] = '{default: 0};
    int          sdclk_edges = 0;
    int          cycles = 0;
    logic [31:0] scan_regs [8] = '{32'd0, {8'd0, 8'(HBP), 8'(HSYNC), 8'(HFP)}, 32'(HACT),
                                   {8'd0, 8'(VBP), 8'(VSYNC), 8'(VFP)}, 32'(VACT),
                                   32'(LUT_FR), 32'd0, 32'd1};

    epd_controller #(
        .H_FP(HFP), .H_SYNC(HSYNC), .H_BP(HBP), .H_ACT(HACT),
        .V_FP(VFP), .V_SYNC(VSYNC), .V_BP(VBP), .V_ACT(VACT),
        .LUT_FRAMES(LUT_FR), .VS_DELAY(VS_DELAY), .PIPELINE_DELAY(2)
    ) dut0 (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] reg_mask(input int adr);
        case (adr)
            0: return 32'h1;
            1, 3: return 32'hff_ffff;
            2, 4: return 32'hfff;
            5: return 32'h3f;
            default: return 32'h0;
        endcase
    endfunction

    // Expected drive codes and new states for one beat of four pixels
    function automatic logic [71:0] pixel_model(input logic [31:0] pix, input logic [63:0] sw);
        logic [15:0] st, nst;
        logic [3:0]  src, tgt, y4;
        logic [5:0]  left;
        logic [13:0] a;
        logic [7:0]  tbyte, sd;
        logic [63:0] bo;
        for (int i = 0; i < 4; i++) begin
            st = sw[16*i +: 16];
            nst = st;
            src = st[3:0];
            tgt = st[7:4];
            left = st[13:8];
            y4 = pix[8*i + 4 +: 4];
            sd[2*i +: 2] = 2'b00;
            if (left == 0) begin
                if (y4 != src) begin
                    nst[7:4] = y4;
                    nst[13:8] = 6'(LUT_FR);
                end
            end else begin
                a = {6'(LUT_FR) - left, tgt, src};
                tbyte = tbl[a[13:2]];
                sd[2*i +: 2] = tbyte[2*a[1:0] +: 2];
                nst[13:8] = left - 6'd1;
                if (left == 6'd1) nst[3:0] = tgt;
            end
            bo[16*i +: 16] = nst;
        end
        return {sd, bo};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: time %0t, signal %s, got %h, expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // One Wishbone classic cycle, returns right after the edge that follows the ack
    task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdat;
        do @(posedge clk); while (!wb_ack);
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        @(posedge clk);
        check_value("wb_ack", wb_ack, 1'b0);
    endtask

    task automatic write_reg(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic expect_reg(input logic [2:0] adr, input logic [31:0] exp);
        logic [31:0] d;
        bus_access(1'b0, adr, 32'd0, d);
        check_value($sformatf("wb_dat_r@%0d", adr), d, exp);
    endtask

    // Output checks, beat capture and fresh upstream data every cycle
    always @(posedge clk) begin
        logic [71:0] exp_beat;
        logic [63:0] st_word;
        if (rst) begin
            rdy_d1 <= 1'b0;
            rdy_d2 <= 1'b0;
            sdle_d <= 1'b0;
        end else begin
            check_value("bi_ready", bi_ready, vin_ready);
            check_value("bo_valid", bo_valid, rdy_d2);
            check_value("epd_sdce0", epd_sdce0, !rdy_d2);
            // Gate clock rises the cycle after the sync pulse
            if (epd_sdle || sdle_d) check_value("epd_gdclk", epd_gdclk, sdle_d);
            if (bo_valid) begin
                exp_beat = exp_q.pop_front();
                check_value("epd_sd", epd_sd, exp_beat[71:64]);
                check_value("bo_pixel", bo_pixel, exp_beat[63:0]);
            end else begin
                check_value("epd_sd", epd_sd, 8'd0);
            end
            if (vin_ready) exp_q.push_back(pixel_model(vin_pixel, bi_pixel));
            rdy_d1 <= vin_ready;
            rdy_d2 <= rdy_d1;
            sdle_d <= epd_sdle;
            cnt[0] <= cnt[0] + int'(epd_sdle && !sdle_d);
            cnt[1] <= cnt[1] + int'(!epd_gdsp);
            cnt[2] <= cnt[2] + int'(!epd_sdce0);
            cnt[3] <= cnt[3] + int'(vin_ready);
            cnt[4] <= cnt[4] + int'(bo_valid);
            cnt[5] <= cnt[5] + int'(epd_gdoe);
            cnt[6] <= cnt[6] + int'(epd_sdoe);
            cnt[7] <= cnt[7] + int'(epd_gdclk);
        end
        // Frames left stays within the programmed frame count
        for (int i = 0; i < 4; i++) begin
            pix_rng = lcg_next(pix_rng);
            st_word[16*i +: 16] = {pix_rng[31:30], 6'(pix_rng[29:24] % (LUT_FR + 1)),
                                   pix_rng[23:16]};
        end
        pix_rng = lcg_next(pix_rng);
        vin_pixel <= pix_rng;
        bi_pixel <= st_word;
    end

    // Source clock pulses
    always @(posedge epd_sdclk) begin
        sdclk_edges <= sdclk_edges + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial begin
        logic [31:0] d;
        int base [8];
        int sdclk_base;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 3'd0;
        wb_dat_w = 32'd0;
        vin_vsync = 1'b0;
        vin_valid = 1'b1;
        bi_valid = 1'b1;
        vin_pixel = 32'd0;
        bi_pixel = 64'd0;
        sys_ready = 1'b1;
        rng = SEED;
        pix_rng = ~SEED;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset values, then random writes with readback
        for (int a = 0; a < 8; a++) expect_reg(3'(a), scan_regs[a]);
        for (int r = 0; r < 3; r++) begin
            for (int a = 0; a < 8; a++) begin
                rng = lcg_next(rng);
                write_reg(3'(a), rng);
                if (a == 6) tbl[rng[19:8]] = rng[7:0];
                expect_reg(3'(a), (a == 7) ? 32'h1 : (rng & reg_mask(a)));
            end
        end
        for (int a = 0; a < 6; a++) write_reg(3'(a), scan_regs[a]);
        for (int a = 0; a < 8; a++) expect_reg(3'(a), scan_regs[a]);

        // Disabled controller ignores vsync
        base = cnt;
        vin_vsync <= 1'b1;
        @(posedge clk);
        vin_vsync <= 1'b0;
        repeat (20) @(posedge clk);
        check_value("vin_ready cycles", cnt[3] - base[3], 0);
        check_value("global_en", global_en, 1'b0);
        expect_reg(REG_STATUS, 32'h1);

        for (int b = 0; b < LUT_BYTES; b++) begin
            rng = lcg_next(rng);
            tbl[b] = rng[31:24];
            write_reg(REG_LUTWR, {12'd0, 12'(b), rng[31:24]});
        end
        write_reg(REG_CTRL, 32'h1);
        check_value("global_en", global_en, 1'b1);

        for (int f = 0; f < N_FRAMES; f++) begin
            base = cnt;
            sdclk_base = sdclk_edges;
            vin_vsync <= 1'b1;
            @(posedge clk);
            vin_vsync <= 1'b0;
            d = 32'd0;
            while (!d[1]) bus_access(1'b0, REG_STATUS, 32'd0, d);
            while (d[1]) bus_access(1'b0, REG_STATUS, 32'd0, d);
            repeat (3) @(posedge clk);
            check_value("epd_sdle pulses", cnt[0] - base[0], VTOTAL);
            check_value("epd_gdsp low cycles", cnt[1] - base[1], VSYNC * HTOTAL);
            check_value("epd_sdce0 low cycles", cnt[2] - base[2], VACT * HACT);
            check_value("vin_ready cycles", cnt[3] - base[3], VACT * HACT);
            check_value("bo_valid cycles", cnt[4] - base[4], cnt[3] - base[3]);
            check_value("epd_gdoe high cycles", cnt[5] - base[5],
                        (VSYNC + VBP + VACT) * HTOTAL);
            check_value("epd_sdoe high cycles", cnt[6] - base[6],
                        (VSYNC + VBP + VACT) * HTOTAL);
            check_value("epd_gdclk high cycles", cnt[7] - base[7],
                        VTOTAL * (HSYNC + HBP + HACT));
            check_value("epd_sdclk pulses", sdclk_edges - sdclk_base,
                        VTOTAL * (HFP + HSYNC + HACT));
            check_value("pending beats", exp_q.size(), 0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

/* sim.f */
design/epd_pkg.sv
design/csr_wb.sv
design/scan_timing.sv
design/wvfm_lut.sv
design/pixel_pipeline.sv
design/epd_controller.sv
sim/epd_assert.sv
sim/tb_epd.sv
